// File: hdl/opl3_cfg.svh
// ------------------------------
// opl3 slot fetch configuration
// bank, slot and register group constants
// ------------------------------
`ifndef OPL3_CFG_SVH
`define OPL3_CFG_SVH

`define OPL3_NUM_BANKS       2
`define OPL3_OPS_PER_BANK    18
`define OPL3_CHANS_PER_BANK  9

// clocks spent on each operator slot
`define OPL3_SLOT_CYCLES     2

// 0x20..0x35 style groups, holes at 6,7 and 14,15
`define OPL3_OP_MEM_DEPTH    22

`define OPL3_BASE_MULT       8'h20  // am/vib/egt/ksr/mult
`define OPL3_BASE_KSL_TL     8'h40  // ksl/tl
`define OPL3_BASE_FNUM_LO    8'hA0  // f-number low byte
`define OPL3_BASE_KON_BLOCK  8'hB0  // kon, block, f-number high
`define OPL3_BASE_FB_CNT     8'hC0  // feedback, connection

`endif

// File: hdl/opl3_slot_pkg.sv
// ------------------------------
// opl3 slot fetch types
// index and register payload types
// ------------------------------
`include "opl3_cfg.svh"

package opl3_slot_pkg;

    // slot and channel numbering
    typedef logic [$clog2(`OPL3_NUM_BANKS)-1:0]      bank_t;
    typedef logic [$clog2(`OPL3_OPS_PER_BANK)-1:0]   op_num_t;
    typedef logic [$clog2(`OPL3_CHANS_PER_BANK)-1:0] chan_t;
    typedef logic [$clog2(`OPL3_OP_MEM_DEPTH)-1:0]   op_idx_t;

    // host register port
    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    // bit bank*3+k pairs channel k with k+3
    typedef logic [`OPL3_NUM_BANKS*3-1:0] conn_sel_t;

    // channel parameter fields
    typedef logic [9:0] fnum_t;
    typedef logic [2:0] block_t;
    typedef logic [2:0] fb_t;

    // stored payloads of the 0xB0 and 0xC0 groups
    typedef logic [4:0] blk_fhi_t;  // {block, fnum[9:8]}
    typedef logic [3:0] fb_cnt_t;   // {fb, cnt}

endpackage

// File: hdl/bank_mem.sv
// ------------------------------
// banked register memory
// one write port, registered read
// ------------------------------
`include "opl3_cfg.svh"

module bank_mem
    import opl3_slot_pkg::*;
#(
    parameter type data_t = reg_data_t,
    parameter int  depth  = `OPL3_OP_MEM_DEPTH
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  bank_t                    wr_bank,
    input  logic [$clog2(depth)-1:0] wr_idx,
    input  data_t                    wr_data,
    input  logic                     rd_en,
    input  bank_t                    rd_bank,
    input  logic [$clog2(depth)-1:0] rd_idx,
    output data_t                    rd_data
);

    data_t mem [`OPL3_NUM_BANKS][depth];  // contents undefined until written

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_bank][wr_idx] <= wr_data;
        end
    end

    // read data holds between strobes
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_bank][rd_idx];
        end
    end

endmodule

// File: hdl/slot_sequencer.sv
// ------------------------------
// slot sequencer
// sweeps all operator slots per sample
// ------------------------------
`include "opl3_cfg.svh"

module slot_sequencer
    import opl3_slot_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    sample_clk_en,
    output logic    rd_en,
    output bank_t   slot_bank,
    output op_num_t slot_op,
    output logic    slot_valid,
    output bank_t   out_bank,
    output op_num_t out_op,
    output logic    sweep_done
);

    localparam int num_slots = `OPL3_NUM_BANKS * `OPL3_OPS_PER_BANK;
    localparam int state_w   = $clog2(num_slots + 1);
    localparam int cyc_w     = (`OPL3_SLOT_CYCLES > 1) ? $clog2(`OPL3_SLOT_CYCLES) : 1;

    logic [state_w-1:0] state;  // 0 = idle, s+1 while serving slot s
    logic [cyc_w-1:0]   cyc;    // cycle within slot
    logic               last_cyc;

    assign last_cyc = (cyc == cyc_w'(`OPL3_SLOT_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= '0;
            cyc   <= '0;
        end else if (state == '0) begin
            cyc <= '0;
            if (sample_clk_en) begin  // only taken while idle
                state <= state_w'(1);
            end
        end else if (last_cyc) begin
            cyc <= '0;
            if (state == state_w'(num_slots)) begin
                state <= '0;  // back to idle after last slot
            end else begin
                state <= state + 1'b1;
            end
        end else begin
            cyc <= cyc + 1'b1;
        end
    end

    // two banks: states above one bank's worth belong to bank 1
    always_comb begin
        if (state == '0) begin
            slot_bank = '0;
            slot_op   = '0;
        end else if (state > state_w'(`OPL3_OPS_PER_BANK)) begin
            slot_bank = bank_t'(1);
            slot_op   = op_num_t'(state - state_w'(`OPL3_OPS_PER_BANK + 1));
        end else begin
            slot_bank = '0;
            slot_op   = op_num_t'(state - 1'b1);
        end
    end

    assign rd_en = (state != '0) && (cyc == '0);  // first cycle of each slot

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_valid <= 1'b0;
            sweep_done <= 1'b0;
        end else begin
            slot_valid <= rd_en;  // lines up with registered read data
            sweep_done <= slot_valid && out_bank == bank_t'(`OPL3_NUM_BANKS - 1)
                          && out_op == op_num_t'(`OPL3_OPS_PER_BANK - 1);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            out_bank <= slot_bank;
            out_op   <= slot_op;
        end
    end

endmodule

// File: hdl/operator_regs.sv
// ------------------------------
// operator register groups
// 0x20 and 0x40 bytes per operator slot
// ------------------------------
`include "opl3_cfg.svh"

module operator_regs
    import opl3_slot_pkg::*;
(
    input  logic      clk,
    input  logic      wr_en,
    input  bank_t     wr_bank,
    input  reg_addr_t wr_addr,
    input  reg_data_t wr_data,
    input  logic      rd_en,
    input  bank_t     slot_bank,
    input  op_num_t   slot_op,
    output reg_data_t mult_byte,
    output reg_data_t ksl_tl
);

    reg_addr_t mult_off;
    reg_addr_t ksl_off;
    logic      mult_wr;
    logic      ksl_wr;
    op_idx_t   rd_idx;

    // below-base addresses wrap high and fail the range check
    assign mult_off = wr_addr - reg_addr_t'(`OPL3_BASE_MULT);
    assign ksl_off  = wr_addr - reg_addr_t'(`OPL3_BASE_KSL_TL);
    assign mult_wr  = wr_en && (mult_off < reg_addr_t'(`OPL3_OP_MEM_DEPTH));
    assign ksl_wr   = wr_en && (ksl_off < reg_addr_t'(`OPL3_OP_MEM_DEPTH));

    // slot to register index, skipping the two holes
    always_comb begin
        if (slot_op < op_num_t'(6)) begin
            rd_idx = op_idx_t'(slot_op);
        end else if (slot_op < op_num_t'(12)) begin
            rd_idx = op_idx_t'(slot_op + op_num_t'(2));
        end else begin
            rd_idx = op_idx_t'(slot_op + op_num_t'(4));
        end
    end

    bank_mem #(
        .data_t(reg_data_t),
        .depth (`OPL3_OP_MEM_DEPTH)
    ) i_mult_mem (
        .clk,
        .wr_en  (mult_wr),
        .wr_bank(wr_bank),
        .wr_idx (op_idx_t'(mult_off)),
        .wr_data(wr_data),
        .rd_en  (rd_en),
        .rd_bank(slot_bank),
        .rd_idx (rd_idx),
        .rd_data(mult_byte)
    );

    bank_mem #(
        .data_t(reg_data_t),
        .depth (`OPL3_OP_MEM_DEPTH)
    ) i_ksl_tl_mem (
        .clk,
        .wr_en  (ksl_wr),
        .wr_bank(wr_bank),
        .wr_idx (op_idx_t'(ksl_off)),
        .wr_data(wr_data),
        .rd_en  (rd_en),
        .rd_bank(slot_bank),
        .rd_idx (rd_idx),
        .rd_data(ksl_tl)
    );

endmodule

// File: hdl/channel_regs.sv
// ------------------------------
// channel register groups
// f-number, block, key-on, feedback per slot
// ------------------------------
`include "opl3_cfg.svh"

module channel_regs
    import opl3_slot_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wr_en,
    input  bank_t     wr_bank,
    input  reg_addr_t wr_addr,
    input  reg_data_t wr_data,
    input  logic      rd_en,
    input  bank_t     slot_bank,
    input  op_num_t   slot_op,
    input  conn_sel_t connection_sel,
    output fnum_t     fnum,
    output block_t    block,
    output logic      kon,
    output fb_t       fb,
    output logic      cnt0,
    output logic      cnt1,
    output logic      use_feedback
);

    localparam int nchan = `OPL3_CHANS_PER_BANK;

    reg_addr_t fnum_off;
    reg_addr_t kon_off;
    reg_addr_t fb_off;
    logic      fnum_wr;
    logic      kon_wr;
    logic      fb_wr;
    chan_t     k;          // op mod 3
    logic [2:0] conn_pos;  // bank*3 + k
    logic      conn_bit;
    chan_t     chan;
    chan_t     cnt1_chan;
    reg_data_t fnum_lo;
    blk_fhi_t  blk_fhi;
    fb_cnt_t   fb_cnt;
    logic [`OPL3_NUM_BANKS-1:0][nchan-1:0] kon_q;

    assign fnum_off = wr_addr - reg_addr_t'(`OPL3_BASE_FNUM_LO);
    assign kon_off  = wr_addr - reg_addr_t'(`OPL3_BASE_KON_BLOCK);
    assign fb_off   = wr_addr - reg_addr_t'(`OPL3_BASE_FB_CNT);
    assign fnum_wr  = wr_en && (fnum_off < reg_addr_t'(nchan));
    assign kon_wr   = wr_en && (kon_off < reg_addr_t'(nchan));
    assign fb_wr    = wr_en && (fb_off < reg_addr_t'(nchan));

    always_comb begin
        k         = chan_t'(slot_op % 3);
        conn_pos  = 3'(slot_bank) * 3'd3 + 3'(k);
        conn_bit  = connection_sel[conn_pos];
        cnt1_chan = '0;
        if (slot_op < op_num_t'(6)) begin
            chan = k;
        end else if (slot_op < op_num_t'(12)) begin
            chan      = conn_bit ? k : k + chan_t'(3);  // 4-op pair reads lower channel
            cnt1_chan = k + chan_t'(3);
        end else begin
            chan = k + chan_t'(6);
        end
    end

    // key-on kept in flops so reset can clear it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kon_q <= '0;
            kon   <= 1'b0;
        end else begin
            if (kon_wr) begin
                kon_q[wr_bank][chan_t'(kon_off)] <= wr_data[5];
            end
            if (rd_en) begin
                kon <= kon_q[slot_bank][chan];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            if (slot_op < op_num_t'(3)
                    || (slot_op >= op_num_t'(12) && slot_op < op_num_t'(15))) begin
                use_feedback <= 1'b1;
            end else if (slot_op >= op_num_t'(6) && slot_op < op_num_t'(9)) begin
                use_feedback <= !conn_bit;  // no feedback when acting as 4-op carrier half
            end else begin
                use_feedback <= 1'b0;
            end
        end
    end

    bank_mem #(.data_t(reg_data_t), .depth(nchan)) i_fnum_lo_mem (
        .clk,
        .wr_en  (fnum_wr),
        .wr_bank(wr_bank),
        .wr_idx (chan_t'(fnum_off)),
        .wr_data(wr_data),
        .rd_en  (rd_en),
        .rd_bank(slot_bank),
        .rd_idx (chan),
        .rd_data(fnum_lo)
    );

    bank_mem #(.data_t(blk_fhi_t), .depth(nchan)) i_blk_fhi_mem (
        .clk,
        .wr_en  (kon_wr),
        .wr_bank(wr_bank),
        .wr_idx (chan_t'(kon_off)),
        .wr_data(blk_fhi_t'(wr_data[4:0])),
        .rd_en  (rd_en),
        .rd_bank(slot_bank),
        .rd_idx (chan),
        .rd_data(blk_fhi)
    );

    bank_mem #(.data_t(fb_cnt_t), .depth(nchan)) i_fb_cnt_mem (
        .clk,
        .wr_en  (fb_wr),
        .wr_bank(wr_bank),
        .wr_idx (chan_t'(fb_off)),
        .wr_data(fb_cnt_t'(wr_data[3:0])),
        .rd_en  (rd_en),
        .rd_bank(slot_bank),
        .rd_idx (chan),
        .rd_data(fb_cnt)
    );

    // second copy of cnt so both halves of a 4-op pair read together
    bank_mem #(.data_t(logic), .depth(nchan)) i_cnt1_mem (
        .clk,
        .wr_en  (fb_wr),
        .wr_bank(wr_bank),
        .wr_idx (chan_t'(fb_off)),
        .wr_data(wr_data[0]),
        .rd_en  (rd_en),
        .rd_bank(slot_bank),
        .rd_idx (cnt1_chan),
        .rd_data(cnt1)
    );

    assign fnum  = {blk_fhi[1:0], fnum_lo};
    assign block = blk_fhi[4:2];
    assign fb    = fb_cnt[3:1];
    assign cnt0  = fb_cnt[0];

endmodule

// File: hdl/slot_fetch_top.sv
// ------------------------------
// slot fetch top
// sequencer plus operator/channel registers
// ------------------------------
`include "opl3_cfg.svh"

module slot_fetch_top
    import opl3_slot_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      sample_clk_en,
    input  logic      wr_en,
    input  bank_t     wr_bank,
    input  reg_addr_t wr_addr,
    input  reg_data_t wr_data,
    input  conn_sel_t connection_sel,
    output logic      slot_valid,
    output bank_t     out_bank,
    output op_num_t   out_op,
    output reg_data_t mult_byte,
    output reg_data_t ksl_tl,
    output fnum_t     fnum,
    output block_t    block,
    output logic      kon,
    output fb_t       fb,
    output logic      cnt0,
    output logic      cnt1,
    output logic      use_feedback,
    output logic      sweep_done
);

    logic    rd_en;      // first cycle of each slot
    bank_t   slot_bank;
    op_num_t slot_op;

    slot_sequencer i_seq (
        .clk,
        .rst_n,
        .sample_clk_en,
        .rd_en,
        .slot_bank,
        .slot_op,
        .slot_valid,
        .out_bank,
        .out_op,
        .sweep_done
    );

    operator_regs i_op_regs (
        .clk,
        .wr_en,
        .wr_bank,
        .wr_addr,
        .wr_data,
        .rd_en,
        .slot_bank,
        .slot_op,
        .mult_byte,
        .ksl_tl
    );

    channel_regs i_ch_regs (
        .clk,
        .rst_n,
        .wr_en,
        .wr_bank,
        .wr_addr,
        .wr_data,
        .rd_en,
        .slot_bank,
        .slot_op,
        .connection_sel,
        .fnum,
        .block,
        .kon,
        .fb,
        .cnt0,
        .cnt1,
        .use_feedback
    );

endmodule

// File: test/clock_gen.sv
// ------------------------------
// testbench clock and reset
// ------------------------------

module clock_gen #(
    parameter int period       = 100,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;  // released on a rising edge
    end

endmodule

// File: test/tb_slot_fetch.sv
// ------------------------------
// slot fetch testbench
// table-driven sweeps against a shadow model
// ------------------------------
`include "opl3_cfg.svh"

module tb_slot_fetch
    import opl3_slot_pkg::*;
();

    localparam int num_rows   = 5;
    localparam int num_writes = 2 * (2 * `OPL3_OP_MEM_DEPTH + 3 * `OPL3_CHANS_PER_BANK);
    localparam int timeout    = num_rows * (num_writes + 80) * 2 * 100;

    // row table: connection_sel, random connection_sel, rewrite, key-on
    localparam bit [5:0] conn_tab [num_rows] = '{6'h00, 6'h00, 6'h00, 6'h00, 6'h3F};
    localparam bit       rand_tab [num_rows] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
    localparam bit       rewr_tab [num_rows] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1};
    localparam bit       kon_tab  [num_rows] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1};

    logic clk, rst_n, sample_clk_en, wr_en;
    bank_t     wr_bank;
    reg_addr_t wr_addr;
    reg_data_t wr_data;
    conn_sel_t connection_sel;
    logic      slot_valid, kon, cnt0, cnt1, use_feedback, sweep_done;
    bank_t     out_bank;
    op_num_t   out_op;
    reg_data_t mult_byte, ksl_tl;
    fnum_t     fnum;
    block_t    block;
    fb_t       fb;

    // shadow copies of everything written
    reg_data_t mult_sh [`OPL3_NUM_BANKS][`OPL3_OP_MEM_DEPTH];
    reg_data_t ksl_sh  [`OPL3_NUM_BANKS][`OPL3_OP_MEM_DEPTH];
    reg_data_t a0_sh   [`OPL3_NUM_BANKS][`OPL3_CHANS_PER_BANK];
    reg_data_t b0_sh   [`OPL3_NUM_BANKS][`OPL3_CHANS_PER_BANK];
    reg_data_t c0_sh   [`OPL3_NUM_BANKS][`OPL3_CHANS_PER_BANK];
    int errors, tests_ok, tests_bad;

    clock_gen #(.period(100), .reset_cycles(4)) i_clk (.clk, .rst_n);

    slot_fetch_top i_dut (
        .clk, .rst_n, .sample_clk_en, .wr_en, .wr_bank, .wr_addr, .wr_data,
        .connection_sel, .slot_valid, .out_bank, .out_op, .mult_byte, .ksl_tl,
        .fnum, .block, .kon, .fb, .cnt0, .cnt1, .use_feedback, .sweep_done
    );

    task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("Fail %s: got %h expected %h", name, act, exp);
            errors++;
        end
    endtask

    task automatic write_reg(input int bank, input int addr, input reg_data_t data);
        @(posedge clk);
        wr_en   <= 1'b1;
        wr_bank <= bank_t'(bank);
        wr_addr <= reg_addr_t'(addr);
        wr_data <= data;
    endtask

    task automatic rewrite_all(input bit set_kon);
        reg_data_t data;
        for (int b = 0; b < `OPL3_NUM_BANKS; b++) begin
            for (int i = 0; i < `OPL3_OP_MEM_DEPTH; i++) begin
                data = reg_data_t'($urandom);
                mult_sh[b][i] = data;
                write_reg(b, `OPL3_BASE_MULT + i, data);
                data = reg_data_t'($urandom);
                ksl_sh[b][i] = data;
                write_reg(b, `OPL3_BASE_KSL_TL + i, data);
            end
            for (int c = 0; c < `OPL3_CHANS_PER_BANK; c++) begin
                data = reg_data_t'($urandom);
                a0_sh[b][c] = data;
                write_reg(b, `OPL3_BASE_FNUM_LO + c, data);
                data = reg_data_t'($urandom);
                data[5] = data[5] & set_kon;  // key-on only where the row allows it
                b0_sh[b][c] = data;
                write_reg(b, `OPL3_BASE_KON_BLOCK + c, data);
                data = reg_data_t'($urandom);
                c0_sh[b][c] = data;
                write_reg(b, `OPL3_BASE_FB_CNT + c, data);
            end
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic check_slot(input int s, input conn_sel_t conn);
        int bank, op, idx, k, ch;
        logic cbit, ufb;
        reg_data_t b0, c0;
        bank = s / `OPL3_OPS_PER_BANK;
        op   = s % `OPL3_OPS_PER_BANK;
        idx  = (op < 6) ? op : (op < 12) ? op + 2 : op + 4;
        k    = op % 3;
        cbit = conn[bank * 3 + k];
        ch   = (op < 6) ? k : (op >= 12) ? 6 + k : (cbit ? k : 3 + k);
        ufb  = (op < 3 || (op >= 12 && op < 15)) ? 1'b1 : (op >= 6 && op < 9) ? !cbit : 1'b0;
        b0   = b0_sh[bank][ch];
        c0   = c0_sh[bank][ch];
        check("out_bank", 32'(out_bank), bank);
        check("out_op", 32'(out_op), op);
        check("mult_byte", 32'(mult_byte), 32'(mult_sh[bank][idx]));
        check("ksl_tl", 32'(ksl_tl), 32'(ksl_sh[bank][idx]));
        check("fnum", 32'(fnum), 32'({b0[1:0], a0_sh[bank][ch]}));
        check("block", 32'(block), 32'(b0[4:2]));
        check("kon", 32'(kon), 32'(b0[5]));
        check("fb", 32'(fb), 32'(c0[3:1]));
        check("cnt0", 32'(cnt0), 32'(c0[0]));
        check("cnt1", 32'(cnt1), 32'(c0_sh[bank][(op >= 6 && op < 12) ? 3 + k : 0][0]));
        check("use_feedback", 32'(use_feedback), 32'(ufb));
    endtask

    task automatic run_sweep(input conn_sel_t conn);
        int n_valid;
        bit done_seen;
        n_valid   = 0;
        done_seen = 1'b0;
        @(posedge clk);
        sample_clk_en  <= 1'b1;
        connection_sel <= conn;
        for (int cyc = 0; cyc < 90 && !done_seen; cyc++) begin
            @(negedge clk);
            if (slot_valid && n_valid >= 2 * `OPL3_OPS_PER_BANK) begin
                $display("extra slot_valid seen after the last slot");
                errors++;
            end else if (slot_valid) begin
                check("valid_cycle", cyc, 2 + 2 * n_valid);
                check_slot(n_valid, conn);
                n_valid++;
            end
            if (sweep_done) begin
                check("done_cycle", cyc, 4 * `OPL3_OPS_PER_BANK + 1);
                done_seen = 1'b1;
            end
            @(posedge clk);
            sample_clk_en <= (cyc == 20);  // stray pulse mid-sweep
        end
        if (!done_seen) begin
            $display("sweep_done never arrived after %0d valid slots", n_valid);
            errors++;
        end
        check("valid_count", n_valid, 2 * `OPL3_OPS_PER_BANK);
        repeat (6) begin
            @(negedge clk);
            check("slot_valid", 32'(slot_valid), 0);
            check("sweep_done", 32'(sweep_done), 0);
        end
    endtask

    task automatic score(input string what, input int err_start);
        if (errors == err_start) begin
            tests_ok++;
            $display("test %s: ok", what);
        end else begin
            tests_bad++;
            $display("test %s: FAILED with %0d errors", what, errors - err_start);
        end
    endtask

    initial begin
        #(timeout);
        $display("run timed out after %0d time units", timeout);
        $display("Something failed");
        $finish;
    end

    initial begin
        int err_start;
        conn_sel_t conn;
        errors    = 0;
        tests_ok  = 0;
        tests_bad = 0;
        sample_clk_en  = 1'b0;
        wr_en          = 1'b0;
        wr_bank        = '0;
        wr_addr        = '0;
        wr_data        = '0;
        connection_sel = '0;
        void'($urandom(43116));
        wait (rst_n === 1'b1);
        err_start = errors;
        repeat (10) begin
            @(negedge clk);
            check("slot_valid", 32'(slot_valid), 0);
            check("sweep_done", 32'(sweep_done), 0);
        end
        score("idle after reset", err_start);
        for (int r = 0; r < num_rows; r++) begin
            err_start = errors;
            conn = rand_tab[r] ? conn_sel_t'($urandom) : conn_tab[r];
            if (rewr_tab[r]) begin
                rewrite_all(kon_tab[r]);
            end
            run_sweep(conn);
            score($sformatf("sweep %0d conn_sel %h", r, conn), err_start);
        end
        $display("tests passed %0d, failed %0d", tests_ok, tests_bad);
        if (errors == 0 && tests_bad == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+hdl
hdl/opl3_slot_pkg.sv
hdl/bank_mem.sv
hdl/slot_sequencer.sv
hdl/operator_regs.sv
hdl/channel_regs.sv
hdl/slot_fetch_top.sv
test/clock_gen.sv
test/tb_slot_fetch.sv

// File: run.sh
#!/bin/sh
# build and run the slot fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 -f flist.f --top-module tb_slot_fetch -Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Everything OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
